// ==== rtl/lc4_pkg.sv ====
// shared widths, types and encodings for the five-stage LC4 pipeline
// every RTL module and the stage interface import this package
package lc4_pkg;

   localparam int LC4_XLEN = 16;  // machine word width

   typedef logic [LC4_XLEN-1:0] word_t;  // data, address or instruction word
   typedef logic [2:0]          reg_sel_t;
   typedef logic [2:0]          nzp_t;   // {n, z, p}

   // top opcodes kept by this core, other encodings stay unnamed
   typedef enum logic [3:0] {
      OP_BR    = 4'b0000,
      OP_ARITH = 4'b0001,
      OP_LOGIC = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001,
      OP_JMP   = 4'b1100
   } lc4_op_e;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOT,
      ALU_PASS_IMM,  // sext(imm9) for CONST
      ALU_ADDR,      // base + sext(imm6)
      ALU_BR_TGT,    // pc + 1 + sext(imm9)
      ALU_JMP_TGT    // pc + 1 + sext(imm11)
   } lc4_alu_e;

   typedef struct packed {
      lc4_alu_e alu_op;
      reg_sel_t rd_sel;
      logic     rf_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      logic     is_branch;
      logic     is_jump;
   } lc4_ctrl_t;

   // bubble, writes nothing
   localparam lc4_ctrl_t LC4_NOP_CTRL = '{alu_op: ALU_ADD, rd_sel: 3'd0, rf_we: 1'b0,
      nzp_we: 1'b0, is_load: 1'b0, is_store: 1'b0, is_branch: 1'b0, is_jump: 1'b0};

endpackage

// ==== rtl/lc4_stage_if.sv ====
// bundle of one instruction as it moves from one pipeline stage to the next
// src side drives all signals, dst side only reads them
interface lc4_stage_if;
   import lc4_pkg::*;

   logic      valid;    // slot holds a live instruction
   word_t     pc;
   word_t     insn;
   lc4_ctrl_t ctrl;     // decoded control, NOP when slot is empty
   word_t     rt_data;  // store data
   word_t     result;   // alu result, then load data after memory

   modport src (output valid, pc, insn, ctrl, rt_data, result);
   modport dst (input valid, pc, insn, ctrl, rt_data, result);

endinterface

// ==== rtl/lc4_fetch.sv ====
// fetch stage: program counter and the fetch/decode register
// instruction memory is read combinationally at o_imem_addr
// a taken branch in writeback redirects the pc and empties the f/d slot
module lc4_fetch #(
   parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
   input  logic           gwe,
   input  logic           i_rst_n,
   input  lc4_pkg::word_t i_imem_insn,
   input  logic           i_redirect,
   input  lc4_pkg::word_t i_target,
   input  logic           i_flush,
   output lc4_pkg::word_t o_imem_addr,
   lc4_stage_if.src       fd
);
   import lc4_pkg::*;

   word_t pc_q;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q     <= RESET_PC;
         fd.valid <= 1'b0;
      end else begin
         pc_q     <= i_redirect ? i_target : pc_q + 1'b1;  // no stall, always moves
         fd.valid <= !i_flush;  // squash the insn fetched under a taken branch
      end
   end

   always_ff @(posedge gwe) begin
      fd.pc   <= pc_q;
      fd.insn <= i_imem_insn;
   end

   assign o_imem_addr = pc_q;
   assign fd.ctrl     = LC4_NOP_CTRL;  // decode fills these later
   assign fd.rt_data  = '0;
   assign fd.result   = '0;

   // redirect target from writeback must be the next fetch address
   a_redirect_pc: assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_redirect |=> (pc_q == $past(i_target)))
      else $error("fetch pc %h does not follow redirect target", pc_q);

endmodule

// ==== rtl/lc4_decoder.sv ====
// instruction decoder, purely combinational
// gives the register file read selects and the control bundle for execute
// encodings outside the kept set decode as a bubble
module lc4_decoder (
   input  lc4_pkg::word_t    i_insn,
   output lc4_pkg::reg_sel_t o_rs_sel,
   output lc4_pkg::reg_sel_t o_rt_sel,
   output lc4_pkg::lc4_ctrl_t o_ctrl
);
   import lc4_pkg::*;

   lc4_op_e op;
   logic    wr;  // writes rd and nzp

   assign op       = lc4_op_e'(i_insn[15:12]);
   assign o_rs_sel = i_insn[8:6];  // also the base for LDR/STR
   assign o_rt_sel = (op == OP_STR) ? i_insn[11:9] : i_insn[2:0];  // STR data sits in [11:9]

   always_comb begin
      o_ctrl = LC4_NOP_CTRL;
      wr     = 1'b0;
      case (op)
         OP_BR: begin
            o_ctrl.alu_op    = ALU_BR_TGT;
            o_ctrl.is_branch = 1'b1;  // nzp mask 000 never taken, so NOP falls out
         end
         OP_ARITH: begin
            casez (i_insn[5:3])
               3'b000, 3'b1??: begin o_ctrl.alu_op = ALU_ADD; wr = 1'b1; end  // reg or imm5
               3'b010:         begin o_ctrl.alu_op = ALU_SUB; wr = 1'b1; end
               default:        ;  // MUL, DIV not supported
            endcase
         end
         OP_LOGIC: begin
            case (i_insn[5:3])
               3'b000:  begin o_ctrl.alu_op = ALU_AND; wr = 1'b1; end
               3'b001:  begin o_ctrl.alu_op = ALU_NOT; wr = 1'b1; end
               3'b010:  begin o_ctrl.alu_op = ALU_OR;  wr = 1'b1; end
               3'b011:  begin o_ctrl.alu_op = ALU_XOR; wr = 1'b1; end
               default: ;  // AND immediate dropped
            endcase
         end
         OP_LDR: begin
            o_ctrl.alu_op  = ALU_ADDR;
            o_ctrl.is_load = 1'b1;
            wr             = 1'b1;
         end
         OP_STR: begin
            o_ctrl.alu_op   = ALU_ADDR;
            o_ctrl.is_store = 1'b1;
         end
         OP_CONST: begin
            o_ctrl.alu_op = ALU_PASS_IMM;
            wr            = 1'b1;
         end
         OP_JMP: begin
            if (i_insn[11]) begin  // JMP imm11 only, JMPR dropped
               o_ctrl.alu_op  = ALU_JMP_TGT;
               o_ctrl.is_jump = 1'b1;
            end
         end
         default: ;
      endcase
      if (wr) begin
         o_ctrl.rd_sel = i_insn[11:9];
         o_ctrl.rf_we  = 1'b1;
         o_ctrl.nzp_we = 1'b1;
      end
   end

endmodule

// ==== rtl/lc4_regfile.sv ====
// eight 16-bit registers, two combinational read ports, one write port
// a read of the register being written this cycle returns the new data
module lc4_regfile (
   input  logic              gwe,
   input  logic              i_rst_n,
   input  lc4_pkg::reg_sel_t i_rs_sel,
   input  lc4_pkg::reg_sel_t i_rt_sel,
   output lc4_pkg::word_t    o_rs_data,
   output lc4_pkg::word_t    o_rt_data,
   input  lc4_pkg::reg_sel_t i_rd_sel,
   input  lc4_pkg::word_t    i_wdata,
   input  logic              i_we
);
   import lc4_pkg::*;

   word_t regs [8];

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_rd_sel] <= i_wdata;
      end
   end

   // write-through, the only forwarding path in the core
   assign o_rs_data = (i_we && i_rd_sel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
   assign o_rt_data = (i_we && i_rd_sel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

   a_wdata_known: assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_we |-> !$isunknown({i_rd_sel, i_wdata}))
      else $error("unknown value written to r%0d", i_rd_sel);

endmodule

// ==== rtl/lc4_execute.sv ====
// execute stage: decode/execute register and the ALU
// the ALU also forms load/store addresses and branch/jump targets
module lc4_execute (
   input  logic               gwe,
   input  logic               i_rst_n,
   input  logic               i_flush,
   lc4_stage_if.dst           fd,
   input  lc4_pkg::lc4_ctrl_t i_ctrl,
   input  lc4_pkg::word_t     i_rs_data,
   input  lc4_pkg::word_t     i_rt_data,
   lc4_stage_if.src           xm
);
   import lc4_pkg::*;

   logic      dx_valid;
   lc4_ctrl_t dx_ctrl;
   word_t     dx_pc, dx_insn, dx_rs, dx_rt;
   word_t     imm5, imm6, imm9, imm11, pc_inc, alu_res;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         dx_valid <= 1'b0;
         dx_ctrl  <= LC4_NOP_CTRL;
      end else begin
         dx_valid <= fd.valid && !i_flush;
         dx_ctrl  <= (fd.valid && !i_flush) ? i_ctrl : LC4_NOP_CTRL;  // bubble on squash
      end
   end

   always_ff @(posedge gwe) begin
      dx_pc   <= fd.pc;
      dx_insn <= fd.insn;
      dx_rs   <= i_rs_data;
      dx_rt   <= i_rt_data;
   end

   // sign-extended immediates
   assign imm5   = {{11{dx_insn[4]}}, dx_insn[4:0]};
   assign imm6   = {{10{dx_insn[5]}}, dx_insn[5:0]};
   assign imm9   = {{7{dx_insn[8]}}, dx_insn[8:0]};
   assign imm11  = {{5{dx_insn[10]}}, dx_insn[10:0]};
   assign pc_inc = dx_pc + 1'b1;

   always_comb begin
      case (dx_ctrl.alu_op)
         ALU_ADD:      alu_res = dx_rs + (dx_insn[5] ? imm5 : dx_rt);  // bit 5 picks imm form
         ALU_SUB:      alu_res = dx_rs - dx_rt;
         ALU_AND:      alu_res = dx_rs & dx_rt;
         ALU_OR:       alu_res = dx_rs | dx_rt;
         ALU_XOR:      alu_res = dx_rs ^ dx_rt;
         ALU_NOT:      alu_res = ~dx_rs;
         ALU_PASS_IMM: alu_res = imm9;
         ALU_ADDR:     alu_res = dx_rs + imm6;
         ALU_BR_TGT:   alu_res = pc_inc + imm9;
         ALU_JMP_TGT:  alu_res = pc_inc + imm11;
         default:      alu_res = '0;
      endcase
   end

   assign xm.valid   = dx_valid;
   assign xm.pc      = dx_pc;
   assign xm.insn    = dx_insn;
   assign xm.ctrl    = dx_ctrl;
   assign xm.rt_data = dx_rt;   // store data rides along
   assign xm.result  = alu_res;

endmodule

// ==== rtl/lc4_memory.sv ====
// memory stage: execute/memory register and the data memory port
// loads replace the ALU result with the read data from the same cycle
module lc4_memory (
   input  logic           gwe,
   input  logic           i_rst_n,
   input  logic           i_flush,
   lc4_stage_if.dst       xm,
   input  lc4_pkg::word_t i_dmem_rdata,
   output lc4_pkg::word_t o_dmem_addr,
   output logic           o_dmem_we,
   output lc4_pkg::word_t o_dmem_wdata,
   lc4_stage_if.src       mw
);
   import lc4_pkg::*;

   logic      m_valid;
   logic      live;  // not killed by a taken branch now in writeback
   lc4_ctrl_t m_ctrl;
   word_t     m_pc, m_insn, m_rt, m_res;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         m_valid <= 1'b0;
         m_ctrl  <= LC4_NOP_CTRL;
      end else begin
         m_valid <= xm.valid && !i_flush;
         m_ctrl  <= (xm.valid && !i_flush) ? xm.ctrl : LC4_NOP_CTRL;
      end
   end

   always_ff @(posedge gwe) begin
      m_pc   <= xm.pc;
      m_insn <= xm.insn;
      m_rt   <= xm.rt_data;
      m_res  <= xm.result;
   end

   assign live = m_valid && !i_flush;  // youngest squashed slot sits here

   assign o_dmem_addr  = (m_ctrl.is_load || m_ctrl.is_store) ? m_res : '0;
   assign o_dmem_we    = live && m_ctrl.is_store;
   assign o_dmem_wdata = m_rt;

   assign mw.valid   = live;
   assign mw.pc      = m_pc;
   assign mw.insn    = m_insn;
   assign mw.ctrl    = m_ctrl;
   assign mw.rt_data = m_rt;
   assign mw.result  = m_ctrl.is_load ? i_dmem_rdata : m_res;  // load data wins

endmodule

// ==== rtl/lc4_writeback.sv ====
// writeback stage: memory/writeback register, NZP register and branch resolve
// a taken branch or jump raises redirect and flush for one cycle
// o_valid, o_pc, o_insn and o_nzp_we feed the writeback trace at the top
module lc4_writeback (
   input  logic              gwe,
   input  logic              i_rst_n,
   lc4_stage_if.dst          mw,
   output logic              o_rf_we,
   output lc4_pkg::reg_sel_t o_rf_sel,
   output lc4_pkg::word_t    o_rf_wdata,
   output logic              o_redirect,
   output logic              o_flush,
   output lc4_pkg::word_t    o_target,
   output lc4_pkg::nzp_t     o_nzp,
   output logic              o_valid,
   output lc4_pkg::word_t    o_pc,
   output lc4_pkg::word_t    o_insn,
   output logic              o_nzp_we
);
   import lc4_pkg::*;

   logic      w_valid;
   logic      taken;
   lc4_ctrl_t w_ctrl;
   word_t     w_pc, w_insn, w_res;
   nzp_t      nzp_q, nzp_new;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         w_valid <= 1'b0;
         w_ctrl  <= LC4_NOP_CTRL;
         nzp_q   <= '0;
      end else begin
         w_valid <= mw.valid;
         w_ctrl  <= mw.valid ? mw.ctrl : LC4_NOP_CTRL;
         if (o_nzp_we) nzp_q <= nzp_new;  // seen by the very next insn in W
      end
   end

   always_ff @(posedge gwe) begin
      w_pc   <= mw.pc;
      w_insn <= mw.insn;
      w_res  <= mw.result;
   end

   // sign of the written value
   assign nzp_new = w_res[15] ? 3'b100 : (w_res == '0) ? 3'b010 : 3'b001;

   assign taken = w_valid && (w_ctrl.is_jump ||
                              (w_ctrl.is_branch && |(w_insn[11:9] & nzp_q)));

   assign o_redirect = taken;
   assign o_flush    = taken;
   assign o_target   = w_res;  // target came from the ALU
   assign o_rf_we    = w_valid && w_ctrl.rf_we;
   assign o_rf_sel   = w_ctrl.rd_sel;
   assign o_rf_wdata = w_res;
   assign o_nzp      = nzp_new;
   assign o_nzp_we   = w_valid && w_ctrl.nzp_we;
   assign o_valid    = w_valid;
   assign o_pc       = w_pc;
   assign o_insn     = w_insn;

   // flush needs a live control insn, and the slot behind it is always squashed
   a_flush_src: assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_flush |-> (w_valid && (w_ctrl.is_branch || w_ctrl.is_jump)) ##1 !o_flush)
      else $error("flush at pc %h without a single taken branch", w_pc);

endmodule

// ==== rtl/lc4_processor.sv ====
// five-stage LC4 core with no hazard detection or bypass
// instruction and data memories sit outside and answer in the same cycle
// o_wb_* show each instruction during its writeback cycle
module lc4_processor #(
   parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
   input  logic              gwe,
   input  logic              i_rst_n,
   output lc4_pkg::word_t    o_imem_addr,
   input  lc4_pkg::word_t    i_imem_insn,
   output lc4_pkg::word_t    o_dmem_addr,
   output logic              o_dmem_we,
   output lc4_pkg::word_t    o_dmem_wdata,
   input  lc4_pkg::word_t    i_dmem_rdata,
   output logic              o_wb_valid,
   output lc4_pkg::word_t    o_wb_pc,
   output lc4_pkg::word_t    o_wb_insn,
   output logic              o_wb_rf_we,
   output lc4_pkg::reg_sel_t o_wb_rd,
   output lc4_pkg::word_t    o_wb_data,
   output logic              o_wb_nzp_we,
   output lc4_pkg::nzp_t     o_wb_nzp
);
   import lc4_pkg::*;

   lc4_stage_if fd_if ();
   lc4_stage_if xm_if ();
   lc4_stage_if mw_if ();

   reg_sel_t  rs_sel, rt_sel;
   lc4_ctrl_t dec_ctrl;
   word_t     rs_data, rt_data;
   logic      redirect, flush;
   word_t     target;

   lc4_fetch #(.RESET_PC(RESET_PC)) fetch0 (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_imem_insn(i_imem_insn),
      .i_redirect(redirect), .i_target(target), .i_flush(flush),
      .o_imem_addr(o_imem_addr), .fd(fd_if.src));

   lc4_decoder decoder0 (
      .i_insn(fd_if.insn), .o_rs_sel(rs_sel), .o_rt_sel(rt_sel), .o_ctrl(dec_ctrl));

   // write port is driven from writeback
   lc4_regfile regfile0 (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_rs_sel(rs_sel), .i_rt_sel(rt_sel),
      .o_rs_data(rs_data), .o_rt_data(rt_data),
      .i_rd_sel(o_wb_rd), .i_wdata(o_wb_data), .i_we(o_wb_rf_we));

   lc4_execute execute0 (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_flush(flush), .fd(fd_if.dst),
      .i_ctrl(dec_ctrl), .i_rs_data(rs_data), .i_rt_data(rt_data), .xm(xm_if.src));

   lc4_memory memory0 (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_flush(flush), .xm(xm_if.dst),
      .i_dmem_rdata(i_dmem_rdata), .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we),
      .o_dmem_wdata(o_dmem_wdata), .mw(mw_if.src));

   lc4_writeback writeback0 (
      .gwe(gwe), .i_rst_n(i_rst_n), .mw(mw_if.dst),
      .o_rf_we(o_wb_rf_we), .o_rf_sel(o_wb_rd), .o_rf_wdata(o_wb_data),
      .o_redirect(redirect), .o_flush(flush), .o_target(target),
      .o_nzp(o_wb_nzp), .o_valid(o_wb_valid), .o_pc(o_wb_pc),
      .o_insn(o_wb_insn), .o_nzp_we(o_wb_nzp_we));

endmodule

// ==== include/tb_lc4_prog.svh ====
// program image, data memory preload and expected events for tb_lc4
// included inside the testbench module, word i of PROG sits at RESET_PC + i
// dependent instructions keep two others between them, the core has no bypass
`ifndef TB_LC4_PROG_SVH
`define TB_LC4_PROG_SVH

localparam int PROG_LEN = 32;

localparam logic [15:0] PROG [PROG_LEN] = '{
   16'h9005, 16'h93fd, 16'h94aa,  // CONST r0 5, r1 -3, r2 170
   16'h163e,                      // ADD r3 = r0 + #-2
   16'h1801, 16'h1a50,            // ADD r4 = r0 + r1, SUB r5 = r1 - r0
   16'h5c81, 16'h5e90,            // AND r6 = r2 & r1, OR r7 = r2 | r0
   16'h56dc, 16'h5888,            // XOR r3 = r3 ^ r4, NOT r4 = ~r2
   16'h7e02,                      // STR r7 -> [r0 + 2]
   16'h6202, 16'h643c,            // LDR r1 <- [r0 + 2], LDR r2 <- [r0 - 4]
   16'h1c10,                      // SUB r6 = r0 - r0, zero
   16'h0404,                      // BRz +4, taken
   16'h7e00, 16'h9055,            // squashed: STR, CONST r0
   16'h9255, 16'h9455,            // squashed: CONST r1, r2
   16'h1ba1,                      // branch target, ADD r5 = r6 + #1
   16'h0803,                      // BRn +3, falls through on positive
   16'h9607,                      // CONST r3 7
   16'hc804,                      // JMP +4
   16'h9866, 16'h9a66,            // squashed by the jump
   16'h9c66, 16'h9e66,
   16'h99ff,                      // jump target, CONST r4 -1
   16'h1a08,                      // MUL r5, not supported, writes nothing
   16'h1cc3, 16'h0000,            // ADD r6 = r3 + r3, NOP
   16'h1f60                       // ADD r7 = r5 + #0, r5 still from the target
};

// program words that must never reach writeback
localparam logic [31:0] OFF_PATH = 32'h0787_8000;

localparam logic [15:0] DMEM_INIT [16] = '{
   16'hd000, 16'h1234, 16'hd002, 16'hd003, 16'hd004, 16'hd005, 16'hd006, 16'hd007,
   16'hd008, 16'hd009, 16'hd00a, 16'hd00b, 16'hd00c, 16'hd00d, 16'hd00e, 16'hd00f
};

typedef struct packed {
   logic        is_store;  // 1 store on the data port, 0 register write
   logic [2:0]  test;      // behavior group
   logic [7:0]  pc_ofs;    // program index of the writer
   logic [15:0] key;       // register index or data address
   logic [15:0] value;
} event_t;

localparam int N_EVENTS = 19;

// in program order
localparam event_t EVENTS [N_EVENTS] = '{
   '{1'b0, 3'd1, 8'd0,  16'd0, 16'h0005},
   '{1'b0, 3'd1, 8'd1,  16'd1, 16'hfffd},  // sign-extended imm9
   '{1'b0, 3'd1, 8'd2,  16'd2, 16'h00aa},
   '{1'b0, 3'd1, 8'd3,  16'd3, 16'h0005 + 16'hfffe},
   '{1'b0, 3'd2, 8'd4,  16'd4, 16'h0005 + 16'hfffd},
   '{1'b0, 3'd2, 8'd5,  16'd5, 16'hfffd - 16'h0005},
   '{1'b0, 3'd2, 8'd6,  16'd6, 16'h00aa & 16'hfffd},
   '{1'b0, 3'd2, 8'd7,  16'd7, 16'h00aa | 16'h0005},
   '{1'b0, 3'd2, 8'd8,  16'd3, 16'h0003 ^ 16'h0002},
   '{1'b0, 3'd2, 8'd9,  16'd4, ~16'h00aa},
   '{1'b1, 3'd3, 8'd10, 16'h0005 + 16'h0002, 16'h00af},  // r0 + offset6
   '{1'b0, 3'd3, 8'd11, 16'd1, 16'h00af},  // reads back the store
   '{1'b0, 3'd3, 8'd12, 16'd2, 16'h1234},  // preloaded word at address 1
   '{1'b0, 3'd4, 8'd13, 16'd6, 16'h0005 - 16'h0005},
   '{1'b0, 3'd4, 8'd19, 16'd5, 16'h0000 + 16'h0001},
   '{1'b0, 3'd5, 8'd21, 16'd3, 16'h0007},
   '{1'b0, 3'd5, 8'd27, 16'd4, 16'hffff},
   '{1'b0, 3'd6, 8'd29, 16'd6, 16'h0007 + 16'h0007},
   '{1'b0, 3'd6, 8'd31, 16'd7, 16'h0001 + 16'h0000}
};

`endif

// ==== tb/tb_lc4.sv ====
// testbench for the five-stage LC4 core
// runs the program of tb_lc4_prog.svh from combinational memory models and
// checks register writes in writeback and stores on the data port, in program order
module tb_lc4;
   import lc4_pkg::*;

   localparam word_t RESET_PC = 16'h8200;

   `include "tb_lc4_prog.svh"

   localparam int TIMEOUT = (PROG_LEN + 20) * 4 * 2;

   logic     gwe;
   logic     i_rst_n;
   word_t    imem_addr, dmem_addr, dmem_wdata;
   word_t    imem_insn = 16'h0000;  // NOP until the first fetch
   word_t    dmem_rdata = 16'h0000;
   logic     dmem_we;
   logic     wb_valid, wb_rf_we, wb_nzp_we;
   word_t    wb_pc, wb_insn, wb_data;
   reg_sel_t wb_rd;
   nzp_t     wb_nzp;

   word_t dmem [16];
   int    ev_idx;
   int    err_cnt;
   logic  first_wb;

   lc4_processor #(.RESET_PC(RESET_PC)) dut0 (
      .gwe(gwe), .i_rst_n(i_rst_n),
      .o_imem_addr(imem_addr), .i_imem_insn(imem_insn),
      .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we), .o_dmem_wdata(dmem_wdata),
      .i_dmem_rdata(dmem_rdata),
      .o_wb_valid(wb_valid), .o_wb_pc(wb_pc), .o_wb_insn(wb_insn),
      .o_wb_rf_we(wb_rf_we), .o_wb_rd(wb_rd), .o_wb_data(wb_data),
      .o_wb_nzp_we(wb_nzp_we), .o_wb_nzp(wb_nzp));

   initial begin
      gwe = 1'b0;
      forever #2 gwe = ~gwe;
   end

   function automatic word_t fetch_word(word_t addr);
      word_t ofs;
      ofs = addr - RESET_PC;  // below RESET_PC wraps out of range
      if (ofs < PROG_LEN) begin
         return PROG[ofs];
      end
      return 16'h0000;  // NOP outside the program
   endfunction

   // sign of a value read as signed, {n, z, p}
   function automatic nzp_t nzp_of(word_t v);
      if ($signed(v) < 0) begin
         return 3'b100;
      end else if (v == 16'h0000) begin
         return 3'b010;
      end
      return 3'b001;
   endfunction

   // a program slot writes rd and nzp only if the table lists a register write for it
   function automatic logic writes_reg(word_t ofs);
      for (int i = 0; i < N_EVENTS; i++) begin
         if (!EVENTS[i].is_store && word_t'(EVENTS[i].pc_ofs) == ofs) begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   function automatic string test_name(logic [2:0] t);
      case (t)
         3'd1:    return "reset_const_addi";
         3'd2:    return "alu_ops";
         3'd3:    return "store_load";
         3'd4:    return "brz_taken";
         3'd5:    return "brn_jmp";
         3'd6:    return "unsupported_op";
         default: return "unknown";
      endcase
   endfunction

   // memory models, stores land at the edge, reads answer 1 unit later
   always @(posedge gwe) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 16; i++) begin
            dmem[i] <= DMEM_INIT[i];
         end
      end else if (dmem_we) begin
         dmem[dmem_addr[3:0]] <= dmem_wdata;
      end
      #1;
      imem_insn  = fetch_word(imem_addr);
      dmem_rdata = dmem[dmem_addr[3:0]];
   end

   // compare one observed write with the next row of the event table
   task automatic match_event(input logic is_store, input word_t key, input word_t value);
      event_t ev;
      string  name;
      if (ev_idx >= N_EVENTS) begin
         $display("unexpected %s to %h with value %h after the last expected event",
                  is_store ? "store" : "register write", key, value);
         err_cnt++;
      end else begin
         ev   = EVENTS[ev_idx];
         name = test_name(ev.test);
         if (ev.is_store != is_store) begin
            $display("[ERROR] %s event %0d kind: expected %s, actual %s", name, ev_idx,
                     ev.is_store ? "store" : "register write",
                     is_store ? "store" : "register write");
            err_cnt++;
         end else begin
            if (ev.key != key) begin
               $display("[ERROR] %s event %0d %s: expected %h, actual %h", name, ev_idx,
                        is_store ? "address" : "register", ev.key, key);
               err_cnt++;
            end
            if (ev.value != value) begin
               $display("[ERROR] %s event %0d value: expected %h, actual %h", name, ev_idx,
                        ev.value, value);
               err_cnt++;
            end
            if (!is_store && wb_pc != word_t'(RESET_PC + ev.pc_ofs)) begin
               $display("[ERROR] %s event %0d pc: expected %h, actual %h", name, ev_idx,
                        word_t'(RESET_PC + ev.pc_ofs), wb_pc);
               err_cnt++;
            end
            if (!is_store && wb_nzp != nzp_of(ev.value)) begin
               $display("[ERROR] %s event %0d nzp: expected %b, actual %b", name, ev_idx,
                        nzp_of(ev.value), wb_nzp);
               err_cnt++;
            end
         end
         ev_idx++;
      end
   endtask

   task automatic check_writeback();
      word_t ofs;
      logic  writer;
      ofs    = wb_pc - RESET_PC;
      writer = writes_reg(ofs);
      if (first_wb && wb_pc != RESET_PC) begin
         $display("[ERROR] reset_pc first writeback: expected %h, actual %h", RESET_PC, wb_pc);
         err_cnt++;
      end
      first_wb = 1'b0;
      if (wb_insn != fetch_word(wb_pc)) begin  // trace word must be the one fetched there
         $display("[ERROR] trace_insn pc %h: expected %h, actual %h",
                  wb_pc, fetch_word(wb_pc), wb_insn);
         err_cnt++;
      end
      if (ofs < PROG_LEN && OFF_PATH[ofs]) begin
         $display("instruction at pc %h should have been squashed but reached writeback",
                  wb_pc);
         err_cnt++;
      end
      if (wb_rf_we != writer) begin
         $display("[ERROR] write_enables pc %h rf_we: expected %b, actual %b",
                  wb_pc, writer, wb_rf_we);
         err_cnt++;
      end
      if (wb_nzp_we != writer) begin  // every kept writer sets nzp too
         $display("[ERROR] write_enables pc %h nzp_we: expected %b, actual %b",
                  wb_pc, writer, wb_nzp_we);
         err_cnt++;
      end
      if (wb_rf_we) begin
         match_event(1'b0, {13'd0, wb_rd}, wb_data);
      end
   endtask

   // mid-cycle, so outputs are settled; older writeback goes before the younger store
   task automatic sample_cycle();
      @(negedge gwe);
      if (wb_valid) begin
         check_writeback();
      end
      if (dmem_we) begin
         match_event(1'b1, dmem_addr, dmem_wdata);
      end
   endtask

   initial begin
      i_rst_n  = 1'b0;
      ev_idx   = 0;
      err_cnt  = 0;
      first_wb = 1'b1;
      repeat (2) @(posedge gwe);
      #1 i_rst_n = 1'b1;
      while (ev_idx < N_EVENTS) begin  // walk the event table
         sample_cycle();
      end
      repeat (6) begin
         sample_cycle();  // padding NOPs drain, catches stray writes
      end
      $display("tb_lc4 summary: %0d of %0d events checked, %0d errors",
               ev_idx, N_EVENTS, err_cnt);
      if (err_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(TIMEOUT);
      $display("run timed out after %0d time units with %0d of %0d events seen, %0d errors",
               TIMEOUT, ev_idx, N_EVENTS, err_cnt);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+include
rtl/lc4_pkg.sv
rtl/lc4_stage_if.sv
rtl/lc4_fetch.sv
rtl/lc4_decoder.sv
rtl/lc4_regfile.sv
rtl/lc4_execute.sv
rtl/lc4_memory.sv
rtl/lc4_writeback.sv
rtl/lc4_processor.sv
tb/tb_lc4.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_lc4
FILELIST = files.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
